// ==== src/raster_pkg.sv ====
`default_nettype none

package raster_pkg;

    typedef logic [7:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Intensity is Q0.4 in sixteenths
    typedef struct packed {
        vertex_t    a;
        vertex_t    b;
        vertex_t    c;
        logic [3:0] intensity;
    } triangle_t;

    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic       covered;
        logic [3:0] intensity;
        logic       last;
    } pixel_t;

    typedef enum logic [1:0] {
        IDLE,
        FILL_BACKGROUND,
        RASTERIZE,
        FRAME_DONE
    } draw_state_t;

    // RGB444
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } color_t;

    localparam color_t BACKGROUND_COLOR = '{r: 4'h1, g: 4'h2, b: 4'h6};

    localparam int TRIANGLE_COUNT = 3;

    typedef logic [1:0] tri_index_t;

    // Scene fits a 16 by 12 viewport
    localparam triangle_t SCENE [TRIANGLE_COUNT] = '{
        '{a: '{x: 8'd8,  y: 8'd6},
          b: '{x: 8'd11, y: 8'd1},
          c: '{x: 8'd10, y: 8'd11},
          intensity: 4'd15},
        '{a: '{x: 8'd3,  y: 8'd2},
          b: '{x: 8'd11, y: 8'd1},
          c: '{x: 8'd8,  y: 8'd6},
          intensity: 4'd10},
        '{a: '{x: 8'd8,  y: 8'd6},
          b: '{x: 8'd10, y: 8'd11},
          c: '{x: 8'd3,  y: 8'd2},
          intensity: 4'd5}
    };

endpackage

`default_nettype wire

// ==== src/background_fill.sv ====
`timescale 1ns/1ps
`default_nettype none

module background_fill #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 12,
    localparam int ADDR_W = $clog2(WIDTH * HEIGHT)
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              fill_start,
    output logic              fill_write_en,
    output logic [ADDR_W-1:0] fill_write_addr,
    output logic              fill_done
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(WIDTH * HEIGHT - 1);

    logic              start_q;
    logic              busy;
    logic [ADDR_W-1:0] addr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_q <= 1'b0;
            busy    <= 1'b0;
            addr    <= '0;
        end else begin
            start_q <= fill_start;
            // Restart only on a fresh rising edge of fill_start
            if (fill_start && !start_q) begin
                busy <= 1'b1;
                addr <= '0;
            end else if (busy) begin
                if (addr == LAST_ADDR) begin
                    busy <= 1'b0;
                end else begin
                    addr <= addr + 1'b1;
                end
            end
        end
    end

    assign fill_write_en   = busy;
    assign fill_write_addr = addr;
    assign fill_done       = busy && (addr == LAST_ADDR);

endmodule

`default_nettype wire

// ==== src/triangle_rasterizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module triangle_rasterizer #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 12
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  tri_valid,
    input  raster_pkg::triangle_t tri_data,
    output logic                  tri_ready,
    output logic                  pix_valid,
    output raster_pkg::pixel_t    pix
);

    localparam raster_pkg::coord_t X_MAX = raster_pkg::coord_t'(WIDTH - 1);
    localparam raster_pkg::coord_t Y_MAX = raster_pkg::coord_t'(HEIGHT - 1);

    typedef logic signed [20:0] edge_t;

    // Edge value is a*x + b*y + c
    typedef struct packed {
        edge_t a;
        edge_t b;
        edge_t c;
    } edge_coef_t;

    typedef struct packed {
        raster_pkg::coord_t x_min;
        raster_pkg::coord_t x_max;
        raster_pkg::coord_t y_min;
        raster_pkg::coord_t y_max;
    } bbox_t;

    function automatic edge_coef_t edge_coef(input raster_pkg::vertex_t p,
                                             input raster_pkg::vertex_t q);
        edge_t      dx;
        edge_t      dy;
        edge_coef_t coef;
        dx = edge_t'(q.x) - edge_t'(p.x);
        dy = edge_t'(q.y) - edge_t'(p.y);
        coef.a = -dy;
        coef.b = dx;
        coef.c = dy * edge_t'(p.x) - dx * edge_t'(p.y);
        return coef;
    endfunction

    function automatic edge_t edge_eval(input edge_coef_t coef,
                                        input raster_pkg::coord_t x,
                                        input raster_pkg::coord_t y);
        return coef.a * edge_t'(x) + coef.b * edge_t'(y) + coef.c;
    endfunction

    function automatic raster_pkg::coord_t clamp_min3(input raster_pkg::coord_t a,
                                                      input raster_pkg::coord_t b,
                                                      input raster_pkg::coord_t c,
                                                      input raster_pkg::coord_t lim);
        raster_pkg::coord_t m;
        m = (a < b) ? a : b;
        m = (c < m) ? c : m;
        return (m > lim) ? lim : m;
    endfunction

    function automatic raster_pkg::coord_t clamp_max3(input raster_pkg::coord_t a,
                                                      input raster_pkg::coord_t b,
                                                      input raster_pkg::coord_t c,
                                                      input raster_pkg::coord_t lim);
        raster_pkg::coord_t m;
        m = (a > b) ? a : b;
        m = (c > m) ? c : m;
        return (m > lim) ? lim : m;
    endfunction

    edge_coef_t         coef_in [3];
    bbox_t              box_in;
    edge_t              area_in;
    logic               accept;
    logic               busy;
    logic               at_last;
    logic               covered;
    edge_coef_t         coef [3];
    bbox_t              box;
    logic               winding_neg;
    logic [3:0]         intensity;
    raster_pkg::coord_t x;
    raster_pkg::coord_t y;
    edge_t              e [3];

    // Setup terms straight from the offered triangle
    always_comb begin
        coef_in[0] = edge_coef(tri_data.a, tri_data.b);
        coef_in[1] = edge_coef(tri_data.b, tri_data.c);
        coef_in[2] = edge_coef(tri_data.c, tri_data.a);
        area_in = edge_eval(coef_in[0], tri_data.c.x, tri_data.c.y);
        box_in.x_min = clamp_min3(tri_data.a.x, tri_data.b.x, tri_data.c.x, X_MAX);
        box_in.x_max = clamp_max3(tri_data.a.x, tri_data.b.x, tri_data.c.x, X_MAX);
        box_in.y_min = clamp_min3(tri_data.a.y, tri_data.b.y, tri_data.c.y, Y_MAX);
        box_in.y_max = clamp_max3(tri_data.a.y, tri_data.b.y, tri_data.c.y, Y_MAX);
    end

    assign tri_ready = !busy;
    assign accept    = tri_valid && tri_ready;
    assign at_last   = (x == box.x_max) && (y == box.y_max);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (busy && at_last) begin
            busy <= 1'b0;
        end
    end

    // Row-major scan of the box
    always_ff @(posedge clk) begin
        if (accept) begin
            coef        <= coef_in;
            box         <= box_in;
            winding_neg <= area_in < 0;
            intensity   <= tri_data.intensity;
            x           <= box_in.x_min;
            y           <= box_in.y_min;
        end else if (busy) begin
            if (x == box.x_max) begin
                x <= box.x_min;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            e[i] = edge_eval(coef[i], x, y);
        end
        if (winding_neg) begin
            covered = (e[0] <= 0) && (e[1] <= 0) && (e[2] <= 0);
        end else begin
            covered = (e[0] >= 0) && (e[1] >= 0) && (e[2] >= 0);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= busy;
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            pix <= '{x: x, y: y, covered: covered, intensity: intensity, last: at_last};
        end
    end

endmodule

`default_nettype wire

// ==== src/drawing_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module drawing_manager #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 12,
    localparam int ADDR_W = $clog2(WIDTH * HEIGHT)
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  draw_start,
    input  logic                  draw_ack,
    input  logic [3:0]            sw,
    input  logic                  fill_write_en,
    input  logic [ADDR_W-1:0]     fill_write_addr,
    input  logic                  fill_done,
    input  logic                  tri_ready,
    input  logic                  pix_valid,
    input  raster_pkg::pixel_t    pix,
    output logic                  fill_start,
    output logic                  tri_valid,
    output raster_pkg::triangle_t tri_data,
    output logic                  write_en,
    output logic [ADDR_W-1:0]     write_addr,
    output raster_pkg::color_t    write_data,
    output logic                  frame_done
);

    raster_pkg::draw_state_t state;
    raster_pkg::draw_state_t next_state;
    // Next scene entry to hand over; wraps to 0 once all are handed over
    raster_pkg::tri_index_t  tri_index;
    logic [3:0]              color;
    logic [7:0]              shade;
    logic [ADDR_W-1:0]       pix_addr;

    assign tri_data   = raster_pkg::SCENE[tri_index];
    assign frame_done = (state == raster_pkg::FRAME_DONE);
    assign shade      = color * pix.intensity;
    assign pix_addr   = ADDR_W'(int'(pix.x) + int'(pix.y) * WIDTH);

    always_comb begin
        next_state = state;
        fill_start = 1'b0;
        tri_valid  = 1'b0;
        write_en   = 1'b0;
        write_addr = '0;
        write_data = '0;
        case (state)
            raster_pkg::IDLE: begin
                if (draw_start) begin
                    next_state = raster_pkg::FILL_BACKGROUND;
                end
            end
            raster_pkg::FILL_BACKGROUND: begin
                fill_start = 1'b1;
                write_en   = fill_write_en;
                write_addr = fill_write_addr;
                write_data = raster_pkg::BACKGROUND_COLOR;
                if (fill_done) begin
                    next_state = raster_pkg::RASTERIZE;
                    tri_valid  = 1'b1;
                end
            end
            raster_pkg::RASTERIZE: begin
                if (pix_valid) begin
                    write_en   = pix.covered;
                    write_addr = pix_addr;
                    write_data = '{r: 4'h0, g: shade[7:4], b: 4'h0};
                    if (pix.last) begin
                        if (tri_index == '0) begin
                            next_state = raster_pkg::FRAME_DONE;
                        end else begin
                            tri_valid = 1'b1;
                        end
                    end
                end
            end
            raster_pkg::FRAME_DONE: begin
                if (draw_ack) begin
                    next_state = raster_pkg::FILL_BACKGROUND;
                end
            end
            default: next_state = raster_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= raster_pkg::IDLE;
            tri_index <= '0;
        end else begin
            state <= next_state;
            if (tri_valid && tri_ready) begin
                if (tri_index == raster_pkg::tri_index_t'(raster_pkg::TRIANGLE_COUNT - 1)) begin
                    tri_index <= '0;
                end else begin
                    tri_index <= tri_index + 1'b1;
                end
            end
        end
    end

    // Colour is fixed for the whole frame
    always_ff @(posedge clk) begin
        if (next_state == raster_pkg::FILL_BACKGROUND && state != raster_pkg::FILL_BACKGROUND) begin
            color <= sw;
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_renderer #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 12,
    localparam int ADDR_W = $clog2(WIDTH * HEIGHT)
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               draw_start,
    input  logic               draw_ack,
    input  logic [3:0]         sw,
    output logic               write_en,
    output logic [ADDR_W-1:0]  write_addr,
    output raster_pkg::color_t write_data,
    output logic               frame_done
);

    logic                  fill_start;
    logic                  fill_write_en;
    logic [ADDR_W-1:0]     fill_write_addr;
    logic                  fill_done;
    logic                  tri_valid;
    logic                  tri_ready;
    raster_pkg::triangle_t tri_data;
    logic                  pix_valid;
    raster_pkg::pixel_t    pix;

    drawing_manager #(
        .WIDTH (WIDTH),
        .HEIGHT(HEIGHT)
    ) u_manager (
        .clk            (clk),
        .rstn           (rstn),
        .draw_start     (draw_start),
        .draw_ack       (draw_ack),
        .sw             (sw),
        .fill_write_en  (fill_write_en),
        .fill_write_addr(fill_write_addr),
        .fill_done      (fill_done),
        .tri_ready      (tri_ready),
        .pix_valid      (pix_valid),
        .pix            (pix),
        .fill_start     (fill_start),
        .tri_valid      (tri_valid),
        .tri_data       (tri_data),
        .write_en       (write_en),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .frame_done     (frame_done)
    );

    background_fill #(
        .WIDTH (WIDTH),
        .HEIGHT(HEIGHT)
    ) u_fill (
        .clk            (clk),
        .rstn           (rstn),
        .fill_start     (fill_start),
        .fill_write_en  (fill_write_en),
        .fill_write_addr(fill_write_addr),
        .fill_done      (fill_done)
    );

    triangle_rasterizer #(
        .WIDTH (WIDTH),
        .HEIGHT(HEIGHT)
    ) u_raster (
        .clk      (clk),
        .rstn     (rstn),
        .tri_valid(tri_valid),
        .tri_data (tri_data),
        .tri_ready(tri_ready),
        .pix_valid(pix_valid),
        .pix      (pix)
    );

endmodule

`default_nettype wire

// ==== test/frame_renderer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_renderer_tb;

    localparam int WIDTH = 16;
    localparam int HEIGHT = 12;
    localparam int ADDR_W = $clog2(WIDTH * HEIGHT);
    localparam int PIXELS = WIDTH * HEIGHT;
    localparam int MAX_FRAMES = 64;

    logic               clk;
    logic               rstn;
    logic               draw_start;
    logic               draw_ack;
    logic [3:0]         sw;
    logic               write_en;
    logic [ADDR_W-1:0]  write_addr;
    raster_pkg::color_t write_data;
    logic               frame_done;

    int          seed = 58336;
    int          frame_count;
    int          pat_sw [MAX_FRAMES];
    int          pat_delay [MAX_FRAMES];
    int          pat_count [MAX_FRAMES][3];
    longint      limit_ns;
    bit          patterns_loaded;
    logic [11:0] frame_buffer [PIXELS];

    frame_renderer #(
        .WIDTH (WIDTH),
        .HEIGHT(HEIGHT)
    ) dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .draw_start(draw_start),
        .draw_ack  (draw_ack),
        .sw        (sw),
        .write_en  (write_en),
        .write_addr(write_addr),
        .write_data(write_data),
        .frame_done(frame_done)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Frame-buffer memory model
    always @(posedge clk) begin
        if (write_en === 1'b1) begin
            frame_buffer[write_addr] <= write_data;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Cross product of (q - p) and (s - p)
    function automatic int edge_value(input raster_pkg::vertex_t p, input raster_pkg::vertex_t q,
                                      input int sx, input int sy);
        return (int'(q.x) - int'(p.x)) * (sy - int'(p.y)) -
               (int'(q.y) - int'(p.y)) * (sx - int'(p.x));
    endfunction

    function automatic bit is_covered(input raster_pkg::triangle_t t, input int sx, input int sy);
        int e0;
        int e1;
        int e2;
        int area;
        e0 = edge_value(t.a, t.b, sx, sy);
        e1 = edge_value(t.b, t.c, sx, sy);
        e2 = edge_value(t.c, t.a, sx, sy);
        area = edge_value(t.a, t.b, int'(t.c.x), int'(t.c.y));
        if (area < 0) begin
            return (e0 <= 0) && (e1 <= 0) && (e2 <= 0);
        end
        return (e0 >= 0) && (e1 >= 0) && (e2 >= 0);
    endfunction

    function automatic int clamp_to(input int v, input int lim);
        return (v > lim) ? lim : v;
    endfunction

    function automatic int min3(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic int max3(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    task automatic get_box(input raster_pkg::triangle_t t, output int x0, output int x1,
                           output int y0, output int y1);
        x0 = clamp_to(min3(int'(t.a.x), int'(t.b.x), int'(t.c.x)), WIDTH - 1);
        x1 = clamp_to(max3(int'(t.a.x), int'(t.b.x), int'(t.c.x)), WIDTH - 1);
        y0 = clamp_to(min3(int'(t.a.y), int'(t.b.y), int'(t.c.y)), HEIGHT - 1);
        y1 = clamp_to(max3(int'(t.a.y), int'(t.b.y), int'(t.c.y)), HEIGHT - 1);
    endtask

    // Green level is colour times Q0.4 intensity
    function automatic logic [11:0] shaded_color(input int color, input int intensity);
        logic [3:0] g;
        g = 4'((color * intensity) / 16);
        return {4'h0, g, 4'h0};
    endfunction

    task automatic read_patterns();
        int    fd;
        int    fields;
        int    v [5];
        int    box_sum;
        int    max_delay;
        int    x0;
        int    x1;
        int    y0;
        int    y1;
        string line;
        fd = $fopen("test/frame_patterns.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the pattern file test/frame_patterns.txt");
            $display("ERRORS FOUND");
            $fatal(1, "Missing pattern file");
        end
        frame_count = 0;
        max_delay = 0;
        while (!$feof(fd) && frame_count < MAX_FRAMES) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %d %d %d %d", v[0], v[1], v[2], v[3], v[4]);
                assert (fields == 5) else begin
                    $display("Malformed line in the pattern file: %s", line);
                    $display("ERRORS FOUND");
                    $fatal(1, "Bad pattern line");
                end
                pat_sw[frame_count] = v[0];
                pat_delay[frame_count] = v[1];
                pat_count[frame_count][0] = v[2];
                pat_count[frame_count][1] = v[3];
                pat_count[frame_count][2] = v[4];
                max_delay = (v[1] > max_delay) ? v[1] : max_delay;
                frame_count++;
            end
        end
        $fclose(fd);
        box_sum = 0;
        for (int k = 0; k < raster_pkg::TRIANGLE_COUNT; k++) begin
            get_box(raster_pkg::SCENE[k], x0, x1, y0, y1);
            box_sum += (x1 - x0 + 1) * (y1 - y0 + 1);
        end
        limit_ns = longint'(frame_count) * (PIXELS + box_sum + 3 + max_delay + 50) * 100;
        patterns_loaded = 1'b1;
    endtask

    task automatic run_fill();
        int waited;
        waited = 0;
        @(posedge clk);
        while (write_en !== 1'b1 && waited < 4) begin
            @(posedge clk);
            waited++;
        end
        assert (write_en === 1'b1) else begin
            $display("Background fill did not start within 4 cycles at %0t ns", $time);
            $display("ERRORS FOUND");
            $fatal(1, "Fill missing");
        end
        for (int i = 0; i < PIXELS; i++) begin
            if (i > 0) begin
                @(posedge clk);
            end
            check_value("write_en", write_en, 1);
            check_value("write_addr", write_addr, i);
            check_value("write_data", write_data, raster_pkg::BACKGROUND_COLOR);
            check_value("frame_done", frame_done, 0);
        end
    endtask

    task automatic run_triangles(input int f);
        raster_pkg::triangle_t t;
        int                    x0;
        int                    x1;
        int                    y0;
        int                    y1;
        int                    count;
        bit                    cov;
        for (int k = 0; k < raster_pkg::TRIANGLE_COUNT; k++) begin
            t = raster_pkg::SCENE[k];
            get_box(t, x0, x1, y0, y1);
            count = 0;
            // Setup cycle with another sw change
            @(posedge clk);
            check_value("write_en", write_en, 0);
            @(negedge clk);
            sw = 4'($random(seed));
            for (int y = y0; y <= y1; y++) begin
                for (int x = x0; x <= x1; x++) begin
                    @(posedge clk);
                    cov = is_covered(t, x, y);
                    if (write_en === 1'b1) begin
                        count++;
                    end
                    check_value("write_en", write_en, cov);
                    check_value("frame_done", frame_done, 0);
                    if (cov) begin
                        check_value("write_addr", write_addr, x + y * WIDTH);
                        check_value("write_data", write_data,
                                    shaded_color(pat_sw[f], int'(t.intensity)));
                    end
                end
            end
            check_value($sformatf("triangle %0d write count", k), count, pat_count[f][k]);
        end
    endtask

    task automatic check_buffer(input int color);
        logic [11:0]           expected [PIXELS];
        raster_pkg::triangle_t t;
        int                    x0;
        int                    x1;
        int                    y0;
        int                    y1;
        foreach (expected[a]) begin
            expected[a] = raster_pkg::BACKGROUND_COLOR;
        end
        // Later triangles overwrite earlier ones
        for (int k = 0; k < raster_pkg::TRIANGLE_COUNT; k++) begin
            t = raster_pkg::SCENE[k];
            get_box(t, x0, x1, y0, y1);
            for (int y = y0; y <= y1; y++) begin
                for (int x = x0; x <= x1; x++) begin
                    if (is_covered(t, x, y)) begin
                        expected[x + y * WIDTH] = shaded_color(color, int'(t.intensity));
                    end
                end
            end
        end
        foreach (expected[a]) begin
            check_value($sformatf("frame_buffer[%0d]", a), frame_buffer[a], expected[a]);
        end
    endtask

    task automatic finish_frame(input int f);
        int waited;
        waited = 0;
        @(posedge clk);
        while (frame_done !== 1'b1 && waited < 4) begin
            check_value("write_en", write_en, 0);
            @(posedge clk);
            waited++;
        end
        assert (frame_done === 1'b1) else begin
            $display("frame_done did not rise after the last triangle at %0t ns", $time);
            $display("ERRORS FOUND");
            $fatal(1, "No frame_done");
        end
        check_value("write_en", write_en, 0);
        check_buffer(pat_sw[f]);
        repeat (pat_delay[f]) begin
            @(posedge clk);
            check_value("frame_done", frame_done, 1);
            check_value("write_en", write_en, 0);
        end
    endtask

    initial begin
        wait (patterns_loaded);
        #(limit_ns);
        $display("Watchdog expired before all frames finished rendering");
        $display("ERRORS FOUND");
        $fatal(1, "Timeout");
    end

    initial begin
        int idle_cycles;
        rstn = 1'b0;
        draw_start = 1'b0;
        draw_ack = 1'b0;
        sw = 4'h0;
        read_patterns();
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        idle_cycles = 4 + int'($unsigned($random(seed)) % 8);
        repeat (idle_cycles) begin
            @(posedge clk);
            check_value("write_en", write_en, 0);
            check_value("frame_done", frame_done, 0);
        end
        for (int f = 0; f < frame_count; f++) begin
            @(negedge clk);
            sw = 4'(pat_sw[f]);
            if (f == 0) begin
                draw_start = 1'b1;
            end else begin
                draw_ack = 1'b1;
            end
            @(negedge clk);
            draw_start = 1'b0;
            draw_ack = 1'b0;
            // Mid-frame switch change
            sw = 4'($random(seed));
            run_fill();
            run_triangles(f);
            finish_frame(f);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== frame_renderer.f ====
src/raster_pkg.sv
src/background_fill.sv
src/triangle_rasterizer.sv
src/drawing_manager.sv
src/frame_renderer.sv
test/frame_renderer_tb.sv

// ==== Bender.yml ====
package:
  name: frame_renderer

sources:
  - files:
      - src/raster_pkg.sv
      - src/background_fill.sv
      - src/triangle_rasterizer.sv
      - src/drawing_manager.sv
      - src/frame_renderer.sv
  - target: test
    files:
      - test/frame_renderer_tb.sv

// ==== test/frame_patterns.txt ====
# sw(hex) ack_delay(cycles) covered_tri0 covered_tri1 covered_tri2
# One frame per line, an ack delay of 0 acknowledges at once
f 0 15 21 11
0 3 15 21 11
9 1 15 21 11
5 7 15 21 11
a 0 15 21 11
3 2 15 21 11
c 5 15 21 11
1 0 15 21 11
7 4 15 21 11
e 1 15 21 11
6 0 15 21 11
b 3 15 21 11
